//--- design/srtDivider_consts.svh
`ifndef SRTDIVIDER_CONSTS_SVH
`define SRTDIVIDER_CONSTS_SVH

// operand width
`define DIV_WIDTH 32

// partial remainder carries three extra bits of guard and sign
`define REM_WIDTH 35

// destination register address
`define ARCH_REG_W 5

// radix-4 step counter, up to 16 steps
`define STEP_W 5

// normalization shift, 0 to 32
`define SHIFT_W 6

`endif

//--- design/divCtrlPkg.sv
`include "srtDivider_consts.svh"

package divCtrlPkg;

    typedef enum logic [1:0] {
        opDivW  = 2'd0,
        opDivWu = 2'd1,
        opModW  = 2'd2,
        opModWu = 2'd3
    } divOp_e;

    typedef enum logic [1:0] {stIdle, stIter, stOut} divState_e;

    typedef logic [`ARCH_REG_W-1:0] archReg_t;

endpackage

//--- design/srtArithPkg.sv
`include "srtDivider_consts.svh"

package srtArithPkg;

    // digit code is the digit value in 3-bit two's complement
    typedef enum logic [2:0] {
        qPos2 = 3'b010,
        qPos1 = 3'b001,
        qZero = 3'b000,
        qNeg1 = 3'b111,
        qNeg2 = 3'b110
    } qDigit_e;

    typedef logic [`DIV_WIDTH-1:0] operand_t;
    typedef logic signed [`REM_WIDTH-1:0] partRem_t;

endpackage

//--- design/divOperandPrep.sv
`timescale 1ns/1ps
`include "srtDivider_consts.svh"

module divOperandPrep
    import divCtrlPkg::*;
    import srtArithPkg::*;
(
    input  divOp_e                op,
    input  operand_t              dividend,
    input  operand_t              divisor,
    output operand_t              normDivisor,
    output partRem_t              alignedDividend,
    output logic [`SHIFT_W-1:0]   normShift,
    output logic [`STEP_W-1:0]    stepCount,
    output logic                  quotNeg,
    output logic                  remNeg
);

    logic     isSigned;
    operand_t absDividend;
    operand_t absDivisor;
    logic     found;
    logic     seed;
    partRem_t shiftedDividend;

    function automatic logic [2:0] nibbleLz(input logic [3:0] nib);
        casez (nib)
            4'b1???: nibbleLz = 3'd0;
            4'b01??: nibbleLz = 3'd1;
            4'b001?: nibbleLz = 3'd2;
            default: nibbleLz = 3'd3;
        endcase
    endfunction

    assign isSigned    = (op == opDivW) || (op == opModW);
    assign absDividend = (isSigned && dividend[`DIV_WIDTH-1]) ? -dividend : dividend;
    assign absDivisor  = (isSigned && divisor[`DIV_WIDTH-1]) ? -divisor : divisor;
    assign quotNeg     = isSigned && (dividend[`DIV_WIDTH-1] ^ divisor[`DIV_WIDTH-1]);
    assign remNeg      = isSigned && dividend[`DIV_WIDTH-1];

    // leading zeros, first nonzero nibble from the top
    always_comb begin
        normShift = `SHIFT_W'(`DIV_WIDTH);
        found = 1'b0;
        for (int i = `DIV_WIDTH / 4 - 1; i >= 0; i--) begin
            if (!found && absDivisor[i*4 +: 4] != 4'b0000) begin
                found = 1'b1;
                normShift = `SHIFT_W'(`DIV_WIDTH - 4 - 4 * i) + `SHIFT_W'(nibbleLz(absDivisor[i*4 +: 4]));
            end
        end
    end

    assign normDivisor = absDivisor << normShift;
    assign stepCount   = `STEP_W'(normShift[`SHIFT_W-1:1]) + `STEP_W'(1);

    // odd shift gets one more dividend bit so the step count covers it
    assign shiftedDividend = normShift[0] ? {2'b00, absDividend, 1'b0} : {3'b000, absDividend};

    // large unsigned dividend with odd shift would break the first step bound,
    // so one divisor is taken off up front and credited back to the quotient later
    assign seed = normShift[0] && (absDividend >= normDivisor);
    assign alignedDividend = seed ? shiftedDividend - partRem_t'({1'b0, normDivisor, 2'b00})
                                  : shiftedDividend;

endmodule

//--- design/srtDigitSelect.sv
`timescale 1ns/1ps

module srtDigitSelect
    import srtArithPkg::*;
(
    input  logic [3:0]        divisorTop,
    input  logic signed [5:0] remTop,
    output qDigit_e           digit
);

    // thresholds per row, packed as {m2, m1, m0, mNeg1} in 1/16 units
    logic [23:0]       rowThresh;
    logic signed [5:0] m2;
    logic signed [5:0] m1;
    logic signed [5:0] m0;
    logic signed [5:0] mNeg1;

    always_comb begin
        case (divisorTop)
            4'b1001: rowThresh = {6'sd14, 6'sd4, -6'sd6, -6'sd15};
            4'b1010: rowThresh = {6'sd15, 6'sd4, -6'sd6, -6'sd16};
            4'b1011: rowThresh = {6'sd16, 6'sd4, -6'sd6, -6'sd18};
            4'b1100: rowThresh = {6'sd18, 6'sd6, -6'sd8, -6'sd20};
            4'b1101: rowThresh = {6'sd20, 6'sd6, -6'sd8, -6'sd20};
            4'b1110: rowThresh = {6'sd20, 6'sd8, -6'sd8, -6'sd22};
            4'b1111: rowThresh = {6'sd24, 6'sd8, -6'sd8, -6'sd24};
            // 1000, and unnormalized prefixes that only a zero divisor gives
            default: rowThresh = {6'sd12, 6'sd4, -6'sd4, -6'sd13};
        endcase
    end

    assign m2    = rowThresh[23:18];
    assign m1    = rowThresh[17:12];
    assign m0    = rowThresh[11:6];
    assign mNeg1 = rowThresh[5:0];

    always_comb begin
        if (remTop >= m2) begin
            digit = qPos2;
        end else if (remTop >= m1) begin
            digit = qPos1;
        end else if (remTop >= m0) begin
            digit = qZero;
        end else if (remTop >= mNeg1) begin
            digit = qNeg1;
        end else begin
            digit = qNeg2;
        end
    end

endmodule

//--- design/quotientConvert.sv
`timescale 1ns/1ps
`include "srtDivider_consts.svh"

module quotientConvert
    import srtArithPkg::*;
(
    input  logic     Clk,
    input  logic     rst,
    input  logic     loadEn,
    input  logic     iterEn,
    input  qDigit_e  digit,
    output operand_t quotient
);

    operand_t   qReg;
    operand_t   qmReg;
    operand_t   qSrc;
    operand_t   qmSrc;
    logic [1:0] qLow;
    logic [1:0] qmLow;

    // negative digits borrow from Q-1, positive ones extend Q
    assign qSrc  = digit[2] ? qmReg : qReg;
    assign qmSrc = (digit == qPos2 || digit == qPos1) ? qReg : qmReg;
    assign qLow  = digit[1:0];
    assign qmLow = digit[1:0] - 2'd1;

    always_ff @(posedge Clk) begin
        if (rst || loadEn) begin
            qReg  <= '0;
            qmReg <= '1;
        end else if (iterEn) begin
            qReg  <= {qSrc[`DIV_WIDTH-3:0], qLow};
            qmReg <= {qmSrc[`DIV_WIDTH-3:0], qmLow};
        end
    end

    assign quotient = qReg;

endmodule

//--- design/divRecurrence.sv
`timescale 1ns/1ps
`include "srtDivider_consts.svh"

module divRecurrence
    import srtArithPkg::*;
(
    input  logic                Clk,
    input  logic                rst,
    input  logic                loadEn,
    input  logic                iterEn,
    input  partRem_t            alignedDividend,
    input  operand_t            normDivisor,
    input  logic [`SHIFT_W-1:0] normShift,
    output operand_t            quotientMag,
    output operand_t            remainderMag
);

    partRem_t            remReg;
    operand_t            divReg;
    logic [`SHIFT_W-1:0] shiftReg;
    logic                seedReg;
    partRem_t            divWeight;
    partRem_t            remShifted;
    partRem_t            remNext;
    partRem_t            remFinal;
    logic signed [6:0]   remEst;
    logic signed [5:0]   remTop;
    qDigit_e             digit;
    operand_t            convQuot;
    logic [`DIV_WIDTH:0] seedWeight;

    always_ff @(posedge Clk) begin
        if (loadEn) begin
            remReg   <= alignedDividend;
            divReg   <= normDivisor;
            shiftReg <= normShift;
            seedReg  <= alignedDividend[`REM_WIDTH-1];
        end else if (iterEn) begin
            remReg <= remNext;
        end
    end

    // estimate of 4w, clamped into the table range
    assign remEst = remReg[`REM_WIDTH-1 -: 7];
    assign remTop = (remEst[6] != remEst[5]) ? {remEst[6], {5{~remEst[6]}}} : remEst[5:0];

    srtDigitSelect digitSel_i (.divisorTop(divReg[`DIV_WIDTH-1 -: 4]), .remTop(remTop), .digit(digit));

    quotientConvert conv_i (.Clk(Clk), .rst(rst), .loadEn(loadEn), .iterEn(iterEn),
                            .digit(digit), .quotient(convQuot));

    assign divWeight  = {1'b0, divReg, 2'b00};
    assign remShifted = remReg <<< 2;

    always_comb begin
        unique case (digit)
            qPos2:   remNext = remShifted - partRem_t'({divReg, 3'b000});
            qPos1:   remNext = remShifted - divWeight;
            qNeg1:   remNext = remShifted + divWeight;
            qNeg2:   remNext = remShifted + partRem_t'({divReg, 3'b000});
            default: remNext = remShifted;
        endcase
    end

    assign remFinal     = remReg[`REM_WIDTH-1] ? remReg + divWeight : remReg;
    assign remainderMag = remFinal[`DIV_WIDTH+1:2] >> shiftReg;
    assign seedWeight   = {{`DIV_WIDTH{1'b0}}, seedReg} << (shiftReg + `SHIFT_W'(1));
    assign quotientMag  = (remReg[`REM_WIDTH-1] ? convQuot - operand_t'(1) : convQuot)
                          + seedWeight[`DIV_WIDTH-1:0];

endmodule

//--- design/divSequencer.sv
`timescale 1ns/1ps
`include "srtDivider_consts.svh"

module divSequencer
    import divCtrlPkg::*;
    import srtArithPkg::*;
(
    input  logic               Clk,
    input  logic               rst,
    input  logic               start,
    input  divOp_e             op,
    input  archReg_t           destReg,
    input  logic [`STEP_W-1:0] stepCount,
    input  logic               quotNeg,
    input  logic               remNeg,
    input  operand_t           quotientMag,
    input  operand_t           remainderMag,
    output logic               loadEn,
    output logic               iterEn,
    output operand_t           writeData,
    output archReg_t           writeAddr,
    output logic               writeValid,
    output logic               iqWakeup
);

    divState_e          state;
    logic [`STEP_W-1:0] stepCnt;
    divOp_e             opReg;
    archReg_t           destRegQ;
    logic               quotNegReg;
    logic               remNegReg;
    logic               isMod;
    operand_t           selMag;
    operand_t           result;

    assign loadEn = (state == stIdle) && start;
    assign iterEn = (state == stIter);

    always_ff @(posedge Clk) begin
        if (rst) begin
            state   <= stIdle;
            stepCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin
                        state   <= stIter;
                        stepCnt <= stepCount;
                    end
                end
                stIter: begin
                    if (stepCnt == `STEP_W'(1)) begin
                        state <= stOut;
                    end
                    stepCnt <= stepCnt - `STEP_W'(1);
                end
                // two cycles here, wake-up then write-back
                stOut: begin
                    if (writeValid) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (loadEn) begin
            opReg      <= op;
            destRegQ   <= destReg;
            quotNegReg <= quotNeg;
            remNegReg  <= remNeg;
        end
    end

    assign isMod  = (opReg == opModW) || (opReg == opModWu);
    assign selMag = isMod ? remainderMag : quotientMag;
    assign result = (isMod ? remNegReg : quotNegReg) ? -selMag : selMag;

    assign iqWakeup = (state == stOut) && !writeValid;

    always_ff @(posedge Clk) begin
        if (rst) begin
            writeValid <= 1'b0;
            writeData  <= '0;
            writeAddr  <= '0;
        end else if (iqWakeup) begin
            writeValid <= 1'b1;
            writeData  <= result;
            writeAddr  <= destRegQ;
        end else begin
            writeValid <= 1'b0;
            writeData  <= '0;
            writeAddr  <= '0;
        end
    end

endmodule

//--- design/srtDivider.sv
`timescale 1ns/1ps
`include "srtDivider_consts.svh"

module srtDivider
    import divCtrlPkg::*;
    import srtArithPkg::*;
(
    input  logic     Clk,
    input  logic     rst,
    input  logic     start,
    input  divOp_e   op,
    input  operand_t dividend,
    input  operand_t divisor,
    input  archReg_t destReg,
    output operand_t writeData,
    output archReg_t writeAddr,
    output logic     writeValid,
    output logic     iqWakeup
);

    operand_t            normDivisor;
    partRem_t            alignedDividend;
    logic [`SHIFT_W-1:0] normShift;
    logic [`STEP_W-1:0]  stepCount;
    logic                quotNeg;
    logic                remNeg;
    logic                loadEn;
    logic                iterEn;
    operand_t            quotientMag;
    operand_t            remainderMag;

    divOperandPrep prep_i (
        .op(op), .dividend(dividend), .divisor(divisor),
        .normDivisor(normDivisor), .alignedDividend(alignedDividend),
        .normShift(normShift), .stepCount(stepCount),
        .quotNeg(quotNeg), .remNeg(remNeg)
    );

    divSequencer seq_i (
        .Clk(Clk), .rst(rst), .start(start), .op(op), .destReg(destReg),
        .stepCount(stepCount), .quotNeg(quotNeg), .remNeg(remNeg),
        .quotientMag(quotientMag), .remainderMag(remainderMag),
        .loadEn(loadEn), .iterEn(iterEn), .writeData(writeData),
        .writeAddr(writeAddr), .writeValid(writeValid), .iqWakeup(iqWakeup)
    );

    divRecurrence rec_i (
        .Clk(Clk), .rst(rst), .loadEn(loadEn), .iterEn(iterEn),
        .alignedDividend(alignedDividend), .normDivisor(normDivisor),
        .normShift(normShift), .quotientMag(quotientMag), .remainderMag(remainderMag)
    );

endmodule

//--- tests/srtDividerTb.sv
`timescale 1ns/1ps

module srtDividerTb
    import divCtrlPkg::*;
    import srtArithPkg::*;
();

    localparam int NumRandom = 200;
    localparam int MaxWait   = 40;

    logic     Clk;
    logic     rst;
    logic     start;
    divOp_e   op;
    operand_t dividend;
    operand_t divisor;
    archReg_t destReg;
    operand_t writeData;
    archReg_t writeAddr;
    logic     writeValid;
    logic     iqWakeup;

    int errorCount;
    int checkCount;
    int opsIssued;
    int validCount;
    bit vectorsLoaded;

    divOp_e   goldenOp[$];
    operand_t goldenA[$];
    operand_t goldenB[$];
    archReg_t goldenDest[$];
    operand_t goldenExp[$];

    srtDivider dut_i (
        .Clk(Clk), .rst(rst), .start(start), .op(op),
        .dividend(dividend), .divisor(divisor), .destReg(destReg),
        .writeData(writeData), .writeAddr(writeAddr),
        .writeValid(writeValid), .iqWakeup(iqWakeup)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bit isSignedOp(input divOp_e o);
        return (o == opDivW) || (o == opModW);
    endfunction

    // truncating division, remainder follows the dividend's sign
    function automatic operand_t expectedResult(input divOp_e o, input operand_t a,
                                                input operand_t b);
        operand_t absA;
        operand_t absB;
        operand_t qMag;
        operand_t rMag;
        bit       sgn;
        sgn  = isSignedOp(o);
        absA = (sgn && a[31]) ? -a : a;
        absB = (sgn && b[31]) ? -b : b;
        qMag = absA / absB;
        rMag = absA % absB;
        if (o == opDivW || o == opDivWu) begin
            return (sgn && (a[31] ^ b[31])) ? -qMag : qMag;
        end
        return (sgn && a[31]) ? -rMag : rMag;
    endfunction

    // one radix-4 step per pair of leading zeros, plus one
    function automatic int expectedSteps(input divOp_e o, input operand_t b);
        operand_t absB;
        int       lz;
        absB = (isSignedOp(o) && b[31]) ? -b : b;
        lz = 0;
        while (lz < 32 && absB[31 - lz] == 1'b0) begin
            lz++;
        end
        return lz / 2 + 1;
    endfunction

    task automatic checkData(input string name, input operand_t expected, input operand_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL t=%0t %s expected %08h actual %08h", $time, name, expected, actual);
        end
    endtask

    task automatic checkAddr(input string name, input archReg_t expected, input archReg_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL t=%0t %s expected %02h actual %02h", $time, name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input bit expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL t=%0t %s expected %0b actual %0b", $time, name, expected, actual);
        end
    endtask

    // wake-up must lead each write-back by one cycle, outputs idle otherwise
    task automatic monitorOutputs();
        bit wakeupPrev;
        wakeupPrev = 1'b0;
        forever begin
            @(negedge Clk);
            if (writeValid === 1'b1) begin
                validCount++;
            end else begin
                checkData("writeData", '0, writeData);
                checkAddr("writeAddr", '0, writeAddr);
            end
            checkFlag("writeValid", wakeupPrev, writeValid);
            wakeupPrev = (iqWakeup === 1'b1);
        end
    endtask

    task automatic runOp(input divOp_e opIn, input operand_t a, input operand_t b,
                         input archReg_t dest, input operand_t expData, input bit busyPulse);
        int expSteps;
        int edgeIdx;
        bit seen;
        expSteps = expectedSteps(opIn, b);
        @(posedge Clk);
        start    <= 1'b1;
        op       <= opIn;
        dividend <= a;
        divisor  <= b;
        destReg  <= dest;
        // accepting edge
        @(posedge Clk);
        start <= 1'b0;
        opsIssued++;
        edgeIdx = 0;
        seen = 1'b0;
        while (!seen && edgeIdx <= MaxWait) begin
            @(negedge Clk);
            checkFlag("writeValid", edgeIdx == expSteps + 1, writeValid);
            if (writeValid === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(posedge Clk);
                edgeIdx++;
                if (busyPulse && edgeIdx == 1) begin
                    start    <= 1'b1;
                    op       <= opModWu;
                    dividend <= 32'hffff_ffff;
                    divisor  <= 32'd3;
                    destReg  <= ~dest;
                end else begin
                    start <= 1'b0;
                end
            end
        end
        if (seen) begin
            checkData("writeData", expData, writeData);
            checkAddr("writeAddr", dest, writeAddr);
        end else begin
            errorCount++;
            $display("ERROR: operation %0d gave no write-back within %0d cycles",
                     opsIssued, MaxWait);
        end
    endtask

    initial begin
        int          fd;
        int          lineLen;
        string       line;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] rngState;
        logic [4:0]  shamt;
        logic        flip;
        divOp_e      rOp;
        archReg_t    rDest;
        operand_t    rA;
        operand_t    rB;

        rst        = 1'b1;
        start      = 1'b0;
        op         = opDivW;
        dividend   = '0;
        divisor    = '0;
        destReg    = '0;
        errorCount = 0;
        checkCount = 0;
        opsIssued  = 0;
        validCount = 0;
        rngState   = 32'h1fa1_0e05;

        fd = $fopen("tests/srtDivider_golden.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("ERROR: cannot open tests/srtDivider_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                lineLen = $fgets(line, fd);
                if (lineLen > 0 && $sscanf(line, "%h %h %h %h %h", f0, f1, f2, f3, f4) == 5) begin
                    goldenOp.push_back(divOp_e'(f0[1:0]));
                    goldenA.push_back(f1);
                    goldenB.push_back(f2);
                    goldenDest.push_back(f3[4:0]);
                    goldenExp.push_back(f4);
                end
            end
            $fclose(fd);
        end
        vectorsLoaded = 1'b1;

        repeat (4) @(posedge Clk);
        rst <= 1'b0;
        @(negedge Clk);
        checkFlag("writeValid", 1'b0, writeValid);
        checkFlag("iqWakeup", 1'b0, iqWakeup);
        checkData("writeData", '0, writeData);
        checkAddr("writeAddr", '0, writeAddr);
        fork
            monitorOutputs();
        join_none

        for (int i = 0; i < goldenOp.size(); i++) begin
            runOp(goldenOp[i], goldenA[i], goldenB[i], goldenDest[i], goldenExp[i], 1'b0);
        end

        // a second start while busy must vanish
        runOp(opDivW, 32'd1000, 32'd7, 5'd21, 32'd142, 1'b1);

        for (int n = 0; n < NumRandom; n++) begin
            rngState = nextRandom(rngState);
            rOp      = divOp_e'(rngState[1:0]);
            rDest    = rngState[9:5];
            rngState = nextRandom(rngState);
            rA       = rngState;
            rngState = nextRandom(rngState);
            shamt    = rngState[4:0];
            flip     = rngState[5];
            rngState = nextRandom(rngState);
            rB       = rngState >> shamt;
            if (flip) begin
                rB = -rB;
            end
            if (rB == '0) begin
                rB = 32'd1;
            end
            runOp(rOp, rA, rB, rDest, expectedResult(rOp, rA, rB), 1'b0);
        end

        repeat (6) @(negedge Clk);
        if (validCount != opsIssued) begin
            errorCount++;
            $display("FAIL t=%0t write-back count expected %0d actual %0d",
                     $time, opsIssued, validCount);
        end

        $display("operations %0d, write-backs %0d, checks %0d, errors %0d",
                 opsIssued, validCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // about 20 cycles per operation, with a factor of two margin
    initial begin
        int watchLimit;
        wait (vectorsLoaded);
        watchLimit = (goldenOp.size() + NumRandom + 1) * 20 * 100 * 2;
        #(watchLimit);
        $display("ERROR: the run timed out after %0d ns without finishing", watchLimit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- srtDivider.f
+incdir+design
design/divCtrlPkg.sv
design/srtArithPkg.sv
design/divOperandPrep.sv
design/srtDigitSelect.sv
design/quotientConvert.sv
design/divRecurrence.sv
design/divSequencer.sv
design/srtDivider.sv
tests/srtDividerTb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module srtDividerTb -f srtDivider.f \
    -Mdir obj_dir -o srtDividerSim \
    && ./obj_dir/srtDividerSim | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

//--- tests/srtDivider_golden.txt
// op(0 divW 1 divWu 2 modW 3 modWu) dividend divisor destReg expected, all hex
// directed vectors, divisors chosen for short and long normalization
0 00000064 00000007 01 0000000e
2 00000064 00000007 02 00000002
0 ffffff9c 00000007 03 fffffff2
2 ffffff9c 00000007 04 fffffffe
0 00000064 fffffff9 05 fffffff2
2 00000064 fffffff9 06 00000002
0 ffffff9c fffffff9 07 0000000e
2 ffffff9c fffffff9 08 fffffffe
0 80000000 00000003 09 d5555556
2 80000000 00000003 0a fffffffe
0 80000000 40000000 0b fffffffe
2 80000000 40000000 0c 00000000
0 7fffffff 00000001 0d 7fffffff
2 7fffffff 00000002 0e 00000001
0 00000000 00000005 0f 00000000
0 00000005 00000009 10 00000000
2 00000005 00000009 11 00000005
0 075bcd15 000003e8 12 0001e240
2 075bcd15 000003e8 13 00000315
0 f8a432eb 000003e8 14 fffe1dc0
2 f8a432eb 000003e8 15 fffffceb
1 ffffffff 00000002 16 7fffffff
3 ffffffff 00000002 17 00000001
1 80000000 00000003 18 2aaaaaaa
3 80000000 00000003 19 00000002
1 ffffffff ffffffff 1a 00000001
3 fffffffe ffffffff 1b fffffffe
1 00000064 ffffff9c 1c 00000000
3 00000064 ffffff9c 1d 00000064
1 fffffff0 00000010 1e 0fffffff
3 deadbeef 00010000 1f 0000beef
1 deadbeef 00010000 00 0000dead
